// ==== pix_consts.svh ====
`ifndef PIX_CONSTS_SVH
`define PIX_CONSTS_SVH

// luma coefficients and offset
`define Y_COEF_R      66
`define Y_COEF_G      129
`define Y_COEF_B      25
`define Y_OFFSET      16

// chroma coefficients, both share one offset
`define CR_COEF_R     112
`define CR_COEF_G     (-94)
`define CR_COEF_B     (-18)
`define CB_COEF_R     (-38)
`define CB_COEF_G     (-74)
`define CB_COEF_B     112
`define C_OFFSET      128

// rounding before the divide by 256
`define ROUND_CONST   128
`define ROUND_SHIFT   8

// channel codes, 3 and 7 select nothing
`define SEL_G         3'd0
`define SEL_R         3'd1
`define SEL_B         3'd2
`define SEL_Y         3'd4
`define SEL_CR        3'd5
`define SEL_CB        3'd6

`define SCAN_COUNT_DEFAULT 100000

`endif

// ==== pix_pkg.sv ====
package pix_pkg;

  // packed pixel, {red, green, blue}
  typedef logic [23:0] rgb_t;

  // one colour channel, also used for the lower and upper bounds
  typedef logic [7:0] chan_t;

  // channel code from the switches
  typedef logic [2:0] chan_sel_t;

  // seven segment pattern, bit 0 is segment a
  typedef logic [6:0] seg_t;

  // one-hot digit select, bit 0 is the rightmost digit
  typedef logic [7:0] digit_t;

  // single hex digit
  typedef logic [3:0] nibble_t;

  // display scan counter, wide enough for slow scan rates
  typedef logic [31:0] scan_state_t;

endpackage

// ==== rgb_to_ycrcb.sv ====
`timescale 1ns/10ps
`include "pix_consts.svh"

module rgb_to_ycrcb (
  input  logic           clk_in,
  input  logic           rst_in,
  input  pix_pkg::rgb_t  pix_in,
  input  logic           pix_valid,
  output pix_pkg::chan_t y_out,
  output pix_pkg::chan_t cr_out,
  output pix_pkg::chan_t cb_out,
  output pix_pkg::rgb_t  rgb_out,
  output logic           ycc_valid
);
  import pix_pkg::*;

  // coefficients in r, g, b order
  localparam logic signed [17:0] Y_K [3] = '{18'(`Y_COEF_R), 18'(`Y_COEF_G), 18'(`Y_COEF_B)};
  localparam logic signed [17:0] CR_K [3] = '{18'(`CR_COEF_R), 18'(`CR_COEF_G),
                                              18'(`CR_COEF_B)};
  localparam logic signed [17:0] CB_K [3] = '{18'(`CB_COEF_R), 18'(`CB_COEF_G),
                                              18'(`CB_COEF_B)};
  localparam logic signed [17:0] ROUND = 18'(`ROUND_CONST);
  localparam chan_t Y_OFF = 8'(`Y_OFFSET);
  localparam chan_t C_OFF = 8'(`C_OFFSET);

  logic signed [17:0] comp [3];     // zero-extended r, g, b
  logic signed [17:0] prod_y [3];
  logic signed [17:0] prod_cr [3];
  logic signed [17:0] prod_cb [3];
  logic signed [17:0] sum_y;
  logic signed [17:0] sum_cr;
  logic signed [17:0] sum_cb;
  logic [2:0]         valid_sr;
  rgb_t               rgb_sr [3];

  // divide by 256 then add the offset, result always fits in 8 bits
  function automatic chan_t scale_offset(input logic signed [17:0] sum, input chan_t offset);
    logic signed [17:0] shifted;
    shifted = sum >>> `ROUND_SHIFT;
    return shifted[7:0] + offset;
  endfunction

  assign comp[0] = {10'b0, pix_in[23:16]};
  assign comp[1] = {10'b0, pix_in[15:8]};
  assign comp[2] = {10'b0, pix_in[7:0]};

  // stage 1, nine products
  always_ff @(posedge clk_in) begin
    for (int i = 0; i < 3; i++) begin
      prod_y[i]  <= comp[i] * Y_K[i];
      prod_cr[i] <= comp[i] * CR_K[i];
      prod_cb[i] <= comp[i] * CB_K[i];
    end
  end

  // stage 2, sums with rounding
  always_ff @(posedge clk_in) begin
    sum_y  <= prod_y[0] + prod_y[1] + prod_y[2] + ROUND;
    sum_cr <= prod_cr[0] + prod_cr[1] + prod_cr[2] + ROUND;
    sum_cb <= prod_cb[0] + prod_cb[1] + prod_cb[2] + ROUND;
  end

  // stage 3
  always_ff @(posedge clk_in) begin
    y_out  <= scale_offset(sum_y, Y_OFF);
    cr_out <= scale_offset(sum_cr, C_OFF);
    cb_out <= scale_offset(sum_cb, C_OFF);
  end

  // rgb and valid ride alongside the math
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[1:0], pix_valid};
    end
    rgb_sr[0] <= pix_in;
    rgb_sr[1] <= rgb_sr[0];
    rgb_sr[2] <= rgb_sr[1];
  end

  assign ycc_valid = valid_sr[2];
  assign rgb_out   = rgb_sr[2];

endmodule

// ==== channel_select.sv ====
`timescale 1ns/10ps
`include "pix_consts.svh"

module channel_select (
  input  logic               clk_in,
  input  logic               rst_in,
  input  pix_pkg::chan_sel_t chan_sel_in,
  input  pix_pkg::chan_t     y_in,
  input  pix_pkg::chan_t     cr_in,
  input  pix_pkg::chan_t     cb_in,
  input  pix_pkg::rgb_t      rgb_in,
  input  logic               ycc_valid,
  output pix_pkg::chan_t     chan_out,
  output logic               chan_valid
);
  import pix_pkg::*;

  chan_t chan_next;

  always_comb begin
    case (chan_sel_in)
      `SEL_G:  chan_next = rgb_in[15:8];
      `SEL_R:  chan_next = rgb_in[23:16];
      `SEL_B:  chan_next = rgb_in[7:0];
      `SEL_Y:  chan_next = y_in;
      `SEL_CR: chan_next = cr_in;
      `SEL_CB: chan_next = cb_in;
      default: chan_next = '0;  // codes 3 and 7
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      chan_valid <= 1'b0;
    end else begin
      chan_valid <= ycc_valid;
    end
    if (ycc_valid) begin
      chan_out <= chan_next;  // holds between pixels
    end
  end

endmodule

// ==== threshold_mask.sv ====
`timescale 1ns/10ps

module threshold_mask (
  input  logic           clk_in,
  input  logic           rst_in,
  input  pix_pkg::chan_t chan_in,
  input  pix_pkg::chan_t lt_in,
  input  pix_pkg::chan_t ut_in,
  input  logic           chan_valid,
  output logic           mask_out,
  output logic           mask_valid,
  output pix_pkg::chan_t chan_out
);
  import pix_pkg::*;

  logic in_range;

  // lt > ut can never be met, so the mask stays low
  assign in_range = (chan_in >= lt_in) && (chan_in <= ut_in);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      mask_valid <= 1'b0;
      mask_out   <= 1'b0;
    end else begin
      mask_valid <= chan_valid;
      if (chan_valid) begin
        mask_out <= in_range;
      end
    end
    if (chan_valid) begin
      chan_out <= chan_in;
    end
  end

endmodule

// ==== hex_to_seg.sv ====
`timescale 1ns/10ps

module hex_to_seg (
  input  pix_pkg::nibble_t nibble_in,
  output pix_pkg::seg_t    seg_out
);
  import pix_pkg::*;

  // active high, {g, f, e, d, c, b, a}
  always_comb begin
    case (nibble_in)
      4'h0: seg_out = 7'h3f;
      4'h1: seg_out = 7'h06;
      4'h2: seg_out = 7'h5b;
      4'h3: seg_out = 7'h4f;
      4'h4: seg_out = 7'h66;
      4'h5: seg_out = 7'h6d;
      4'h6: seg_out = 7'h7d;
      4'h7: seg_out = 7'h07;
      4'h8: seg_out = 7'h7f;
      4'h9: seg_out = 7'h6f;
      4'ha: seg_out = 7'h77;
      4'hb: seg_out = 7'h7c;  // lower case b
      4'hc: seg_out = 7'h39;
      4'hd: seg_out = 7'h5e;  // lower case d
      4'he: seg_out = 7'h79;
      default: seg_out = 7'h71;  // F
    endcase
  end

endmodule

// ==== seven_seg_ctrl.sv ====
`timescale 1ns/10ps
`include "pix_consts.svh"

module seven_seg_ctrl #(
  parameter int COUNT_TO = `SCAN_COUNT_DEFAULT
) (
  input  logic               clk_in,
  input  logic               rst_in,
  input  pix_pkg::chan_t     lt_in,
  input  pix_pkg::chan_t     ut_in,
  input  pix_pkg::chan_sel_t chan_sel_in,
  output pix_pkg::seg_t      cat_out,
  output pix_pkg::digit_t    an_out
);
  import pix_pkg::*;

  localparam scan_state_t SCAN_LAST = scan_state_t'(COUNT_TO);

  scan_state_t scan_cnt;
  digit_t      digit_sel;  // one-hot, active high
  nibble_t     routed;
  logic        blank;
  seg_t        seg_lit;

  // scan counter and digit rotation
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      scan_cnt  <= '0;
      digit_sel <= 8'b0000_0001;
    end else if (scan_cnt == SCAN_LAST) begin
      scan_cnt  <= '0;
      digit_sel <= {digit_sel[6:0], digit_sel[7]};
    end else begin
      scan_cnt <= scan_cnt + 1'b1;
    end
  end

  // pick the nibble for the lit digit
  always_comb begin
    routed = '0;
    blank  = 1'b0;
    case (digit_sel)
      8'b0000_0001: routed = {1'b0, chan_sel_in};
      8'b0000_1000: routed = lt_in[3:0];
      8'b0001_0000: routed = lt_in[7:4];
      8'b0100_0000: routed = ut_in[3:0];
      8'b1000_0000: routed = ut_in[7:4];
      default:      blank = 1'b1;  // digits 1, 2 and 5
    endcase
  end

  hex_to_seg u_hex_to_seg (
    .nibble_in (routed),
    .seg_out   (seg_lit)
  );

  // board drives cathodes and anodes low
  assign cat_out = blank ? 7'h7f : ~seg_lit;
  assign an_out  = ~digit_sel;

endmodule

// ==== thresh_top.sv ====
`timescale 1ns/10ps
`include "pix_consts.svh"

module thresh_top #(
  parameter int COUNT_TO = `SCAN_COUNT_DEFAULT
) (
  input  logic               clk_in,
  input  logic               rst_in,
  input  pix_pkg::rgb_t      pix_in,
  input  logic               pix_valid,
  input  pix_pkg::chan_sel_t chan_sel_in,
  input  pix_pkg::chan_t     lt_in,
  input  pix_pkg::chan_t     ut_in,
  output logic               mask_out,
  output logic               mask_valid,
  output pix_pkg::chan_t     chan_out,
  output pix_pkg::seg_t      cat_out,
  output pix_pkg::digit_t    an_out
);
  import pix_pkg::*;

  chan_t y;
  chan_t cr;
  chan_t cb;
  rgb_t  rgb_d;       // rgb delayed to line up with y/cr/cb
  logic  ycc_valid;
  chan_t chan;
  logic  chan_valid;

  rgb_to_ycrcb u_rgb_to_ycrcb (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .pix_in    (pix_in),
    .pix_valid (pix_valid),
    .y_out     (y),
    .cr_out    (cr),
    .cb_out    (cb),
    .rgb_out   (rgb_d),
    .ycc_valid (ycc_valid)
  );

  channel_select u_channel_select (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .chan_sel_in (chan_sel_in),
    .y_in        (y),
    .cr_in       (cr),
    .cb_in       (cb),
    .rgb_in      (rgb_d),
    .ycc_valid   (ycc_valid),
    .chan_out    (chan),
    .chan_valid  (chan_valid)
  );

  threshold_mask u_threshold_mask (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .chan_in    (chan),
    .lt_in      (lt_in),
    .ut_in      (ut_in),
    .chan_valid (chan_valid),
    .mask_out   (mask_out),
    .mask_valid (mask_valid),
    .chan_out   (chan_out)
  );

  // display runs on its own, straight from the switches
  seven_seg_ctrl #(
    .COUNT_TO (COUNT_TO)
  ) u_seven_seg_ctrl (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .lt_in       (lt_in),
    .ut_in       (ut_in),
    .chan_sel_in (chan_sel_in),
    .cat_out     (cat_out),
    .an_out      (an_out)
  );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // released just after an edge, like the other inputs
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #5;
    rst = 1'b0;
  end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/10ps
`include "pix_consts.svh"

module tb_checker #(
  parameter int COUNT_TO = 3
) (
  input  logic               clk_in,
  input  logic               rst_in,
  input  pix_pkg::rgb_t      pix_in,
  input  logic               pix_valid,
  input  pix_pkg::chan_sel_t chan_sel_in,
  input  pix_pkg::chan_t     lt_in,
  input  pix_pkg::chan_t     ut_in,
  input  logic               mask_out,
  input  logic               mask_valid,
  input  pix_pkg::chan_t     chan_out,
  input  pix_pkg::seg_t      cat_out,
  input  pix_pkg::digit_t    an_out,
  output int                 err_count,
  output int                 in_count,
  output int                 out_count,
  output int                 walk_count
);
  import pix_pkg::*;

  // active high, {g, f, e, d, c, b, a}
  localparam seg_t SEG_TABLE [16] = '{
    7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111, 7'b1100110, 7'b1101101,
    7'b1111101, 7'b0000111, 7'b1111111, 7'b1101111, 7'b1110111, 7'b1111100,
    7'b0111001, 7'b1011110, 7'b1111001, 7'b1110001};

  rgb_t pix_q [$];  // pixels in flight
  int   cyc_q [$];  // cycle each one went in
  int   cycle = 0;
  int   errs = 0;
  int   n_in = 0;
  int   n_out = 0;
  int   walks = 0;
  int   digit = 0;  // lit digit as the display should have it
  int   dwell = 0;

  assign err_count  = errs;
  assign in_count   = n_in;
  assign out_count  = n_out;
  assign walk_count = walks;

  function automatic chan_t ycc_ref(input rgb_t p, input int kr, input int kg, input int kb,
                                    input int off);
    int acc;
    acc = kr * int'(p[23:16]) + kg * int'(p[15:8]) + kb * int'(p[7:0]);
    acc = ((acc + `ROUND_CONST) >>> `ROUND_SHIFT) + off;
    return acc[7:0];
  endfunction

  function automatic chan_t chan_ref(input rgb_t p, input chan_sel_t sel);
    chan_t ch;
    case (sel)
      `SEL_R:  ch = p[23:16];
      `SEL_G:  ch = p[15:8];
      `SEL_B:  ch = p[7:0];
      `SEL_Y:  ch = ycc_ref(p, `Y_COEF_R, `Y_COEF_G, `Y_COEF_B, `Y_OFFSET);
      `SEL_CR: ch = ycc_ref(p, `CR_COEF_R, `CR_COEF_G, `CR_COEF_B, `C_OFFSET);
      `SEL_CB: ch = ycc_ref(p, `CB_COEF_R, `CB_COEF_G, `CB_COEF_B, `C_OFFSET);
      default: ch = 8'h00;  // 3 and 7 pick nothing
    endcase
    return ch;
  endfunction

  function automatic logic mask_ref(input chan_t ch, input chan_t lt, input chan_t ut);
    return (ch >= lt) && (ch <= ut);
  endfunction

  // cathodes are active low, blank digits have every segment off
  function automatic seg_t cat_ref(input int d, input chan_sel_t sel, input chan_t lt,
                                   input chan_t ut);
    case (d)
      0: return ~SEG_TABLE[{1'b0, sel}];
      3: return ~SEG_TABLE[lt[3:0]];
      4: return ~SEG_TABLE[lt[7:4]];
      6: return ~SEG_TABLE[ut[3:0]];
      7: return ~SEG_TABLE[ut[7:4]];
      default: return 7'h7f;
    endcase
  endfunction

  // display scan model, each digit lit COUNT_TO+1 cycles
  always @(posedge clk_in) begin
    cycle = cycle + 1;
    if (rst_in) begin
      digit = 0;
      dwell = 0;
    end else if (dwell == COUNT_TO) begin
      dwell = 0;
      digit = (digit + 1) % 8;
      if (digit == 0) begin
        walks = walks + 1;
      end
    end else begin
      dwell = dwell + 1;
    end
  end

  always @(negedge clk_in) begin
    chan_t  exp_chan;
    logic   exp_mask;
    digit_t exp_an;
    seg_t   exp_cat;
    if (!rst_in) begin
      if (pix_valid) begin
        pix_q.push_back(pix_in);
        cyc_q.push_back(cycle);
        n_in = n_in + 1;
      end
      if (mask_valid) begin
        n_out = n_out + 1;
        if (pix_q.size() == 0) begin
          $display("at %0t: mask_valid came with no pixel in flight", $time);
          errs = errs + 1;
        end else begin
          if (cycle - cyc_q[0] != 5) begin
            $display("at %0t: output came %0d cycles after its pixel instead of 5",
                     $time, cycle - cyc_q[0]);
            errs = errs + 1;
          end
          exp_chan = chan_ref(pix_q[0], chan_sel_in);
          exp_mask = mask_ref(exp_chan, lt_in, ut_in);
          if (chan_out !== exp_chan || mask_out !== exp_mask) begin
            $display("error at %0t: pixel %06h sel %0d lt %02h ut %02h gave chan %02h mask %b, %s",
                     $time, pix_q[0], chan_sel_in, lt_in, ut_in, chan_out, mask_out,
                     $sformatf("expected %02h %b", exp_chan, exp_mask));
            errs = errs + 1;
          end
          void'(pix_q.pop_front());
          void'(cyc_q.pop_front());
        end
      end else if (pix_q.size() > 0 && cycle - cyc_q[0] >= 5) begin
        $display("at %0t: pixel %06h never came out", $time, pix_q[0]);
        errs = errs + 1;
        void'(pix_q.pop_front());
        void'(cyc_q.pop_front());
      end
      if (n_out == 0 && mask_out !== 1'b0) begin
        $display("error at %0t: mask_out is %b before any pixel", $time, mask_out);
        errs = errs + 1;
      end
      exp_an  = ~(digit_t'(1) << digit);
      exp_cat = cat_ref(digit, chan_sel_in, lt_in, ut_in);
      if (an_out !== exp_an || cat_out !== exp_cat) begin
        $display("error at %0t: digit %0d shows an %08b cat %07b, expected %08b %07b",
                 $time, digit, an_out, cat_out, exp_an, exp_cat);
        errs = errs + 1;
      end
    end
  end

endmodule

// ==== tb_thresh_top.sv ====
`timescale 1ns/10ps
`include "pix_consts.svh"

module tb_thresh_top;
  import pix_pkg::*;

  localparam int COUNT_TO = 3;
  localparam chan_t EDGES [6] = '{8'h3f, 8'h40, 8'h41, 8'h9f, 8'ha0, 8'ha1};

  logic        clk_in;
  logic        rst_in;
  rgb_t        pix_in;
  logic        pix_valid;
  chan_sel_t   chan_sel_in;
  chan_t       lt_in;
  chan_t       ut_in;
  logic        mask_out;
  logic        mask_valid;
  chan_t       chan_out;
  seg_t        cat_out;
  digit_t      an_out;
  int          err_count;
  int          in_count;
  int          out_count;
  int          walk_count;
  logic        timed_out = 1'b0;
  logic [31:0] lfsr = 32'd69775;

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(8)) u_clock_gen (.clk(clk_in), .rst(rst_in));

  thresh_top #(.COUNT_TO(COUNT_TO)) UUT (
    .clk_in (clk_in), .rst_in (rst_in), .pix_in (pix_in), .pix_valid (pix_valid),
    .chan_sel_in (chan_sel_in), .lt_in (lt_in), .ut_in (ut_in), .mask_out (mask_out),
    .mask_valid (mask_valid), .chan_out (chan_out), .cat_out (cat_out), .an_out (an_out)
  );

  tb_checker #(.COUNT_TO(COUNT_TO)) u_checker (
    .clk_in (clk_in), .rst_in (rst_in), .pix_in (pix_in), .pix_valid (pix_valid),
    .chan_sel_in (chan_sel_in), .lt_in (lt_in), .ut_in (ut_in), .mask_out (mask_out),
    .mask_valid (mask_valid), .chan_out (chan_out), .cat_out (cat_out), .an_out (an_out),
    .err_count (err_count), .in_count (in_count), .out_count (out_count),
    .walk_count (walk_count)
  );

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_in);
    #5;
  endtask

  task automatic print_summary();
    $display("errors %0d, pixels in %0d, pixels out %0d, display walks %0d",
             err_count, in_count, out_count, walk_count);
  endtask

  task automatic record_timeout(input string what);
    $display("timeout: %s", what);
    timed_out = 1'b1;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (in_count != out_count && n < 40) begin
      next_cycle();
      n++;
    end
    if (in_count != out_count) record_timeout("pipeline did not drain within 40 cycles");
  endtask

  task automatic wait_walks(input int count);
    int target;
    int n;
    target = walk_count + count;
    n = 0;
    while (walk_count < target && n < 40 * count + 40) begin
      next_cycle();
      n++;
    end
    if (walk_count < target) record_timeout("display did not finish its digit scan");
  endtask

  task automatic send_pixel(input rgb_t p);
    pix_in    = p;
    pix_valid = 1'b1;
    next_cycle();
    pix_valid = 1'b0;
  endtask

  task automatic send_random(input int count, input logic gaps);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      take_bits(24, r);
      send_pixel(r[23:0]);
      if (gaps) begin
        take_bits(2, r);
        repeat (r[1:0]) next_cycle();
      end
    end
  endtask

  // switches only move once nothing is in flight
  task automatic set_config(input chan_sel_t sel, input chan_t lt, input chan_t ut);
    wait_drained();
    chan_sel_in = sel;
    lt_in       = lt;
    ut_in       = ut;
    repeat (2) next_cycle();
  endtask

  initial begin
    logic [31:0] r;
    int          n;
    pix_in      = '0;
    pix_valid   = 1'b0;
    chan_sel_in = `SEL_R;
    lt_in       = 8'h10;
    ut_in       = 8'he0;
    n = 0;
    while (rst_in !== 1'b0 && n < 20) begin
      next_cycle();
      n++;
    end
    if (rst_in !== 1'b0) record_timeout("reset was never released");
    repeat (10) next_cycle();  // mask_valid must stay low while idle

    for (int sel = 0; sel < 8; sel++) begin
      take_bits(14, r);
      set_config(chan_sel_t'(sel), {1'b0, r[6:0]}, {1'b1, r[13:7]});
      send_random(40, 1'b1);
    end

    // red right on and next to both bounds
    set_config(`SEL_R, 8'h40, 8'ha0);
    for (int i = 0; i < 6; i++) begin
      take_bits(16, r);
      send_pixel({EDGES[i], r[15:0]});
    end
    set_config(`SEL_G, 8'h00, 8'hff);
    send_random(30, 1'b1);
    set_config(`SEL_CB, 8'hc0, 8'h30);  // inverted range
    send_random(30, 1'b1);

    set_config(`SEL_Y, 8'h50, 8'hb0);
    send_random(200, 1'b0);  // back to back

    set_config(`SEL_CR, 8'h12, 8'hfe);
    wait_walks(2);
    set_config(3'd7, 8'ha5, 8'h5a);
    wait_walks(2);
    set_config(`SEL_B, 8'h3c, 8'hd9);
    wait_walks(2);

    wait_drained();
    repeat (5) next_cycle();
    print_summary();
    if (!timed_out && err_count == 0 && in_count > 0 && in_count == out_count) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+.
pix_pkg.sv
rgb_to_ycrcb.sv
channel_select.sv
threshold_mask.sv
hex_to_seg.sv
seven_seg_ctrl.sv
thresh_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_thresh_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_thresh_top -f list.f
sim_out=$(./obj_dir/Vtb_thresh_top)
echo "$sim_out"

if echo "$sim_out" | grep -qx "PASS: all tests"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
